/* Makefile */
# Verilator build for the rv_soc testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+tests
src/rv_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/core.sv
src/inst_mem.sv
src/data_mem.sv
src/rv_soc.sv
tests/tb_rv_soc.sv

/* src/core.sv */
`timescale 1ns/1ns

module core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    output rv_pkg::dmem_req_t       dmem_req_o,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                    exit_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    rv_pkg::decoded_inst_t   dec;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    rf_we;

    inst_decoder i_inst_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (dec.rs1),
        .rs2_addr_i (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (dec.rd),
        .rd_data_i  (wb_data)
    );

    // halt as soon as ecall is fetched
    assign exit_o = (dec.op == rv_pkg::OP_HALT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin
            pc_q <= pc_q + rv_pkg::XLEN'(4);
        end
    end

    assign imem_addr_o = pc_q;

    always_comb begin
        case (dec.op)
            rv_pkg::OP_LW,
            rv_pkg::OP_ADDI: alu_res = rs1_data + dec.imm_i;
            rv_pkg::OP_SW:   alu_res = rs1_data + dec.imm_s;
            rv_pkg::OP_ADD:  alu_res = rs1_data + rs2_data;
            rv_pkg::OP_SUB:  alu_res = rs1_data - rs2_data;
            default:         alu_res = '0;
        endcase
    end

    // memory access
    assign dmem_req_o.addr  = alu_res;
    assign dmem_req_o.wdata = rs2_data;
    assign dmem_req_o.wen   = rst_n && !exit_o && (dec.op == rv_pkg::OP_SW);

    // writeback
    assign rf_we   = (dec.op == rv_pkg::OP_LW) || (dec.op == rv_pkg::OP_ADD) ||
                     (dec.op == rv_pkg::OP_SUB) || (dec.op == rv_pkg::OP_ADDI);
    assign wb_data = (dec.op == rv_pkg::OP_LW) ? dmem_rdata_i : alu_res;

    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req_o.wen && rf_we))
        else $error("memory and register write in the same cycle");

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exit_o |=> $stable(pc_q) && exit_o)
        else $error("pc moved after halt");

endmodule

/* src/data_mem.sv */
`timescale 1ns/1ns

module data_mem (
    input  logic                           clk,
    input  rv_pkg::dmem_req_t              req_i,
    output logic [rv_pkg::XLEN-1:0]        rdata_o,
    input  rv_pkg::mem_load_t              load_i,
    input  logic [rv_pkg::DMEM_ADDR_W-1:0] peek_addr_i,
    output logic [rv_pkg::XLEN-1:0]        peek_data_o
);

    logic [rv_pkg::XLEN-1:0]        mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_ADDR_W-1:0] core_idx;
    logic [rv_pkg::DMEM_ADDR_W-1:0] load_idx;

    assign core_idx = req_i.addr[rv_pkg::DMEM_ADDR_W+1:2];
    assign load_idx = load_i.addr[rv_pkg::DMEM_ADDR_W-1:0];

    assign rdata_o     = mem[core_idx];
    assign peek_data_o = mem[peek_addr_i];

    // loader first
    always_ff @(posedge clk) begin
        if (load_i.we) begin
            mem[load_idx] <= load_i.data;
        end else if (req_i.wen) begin
            mem[core_idx] <= req_i.wdata;
        end
    end

    a_store_addr: assert property (@(posedge clk)
        req_i.wen |-> req_i.addr[1:0] == 2'b00 &&
                      req_i.addr < rv_pkg::XLEN'(rv_pkg::DMEM_WORDS * 4))
        else $error("store address %h misaligned or out of range", req_i.addr);

    // loads only happen under reset, core stores never do
    a_no_collision: assert property (@(posedge clk)
        load_i.we |-> !req_i.wen)
        else $error("load write and core store in the same cycle");

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    output rv_pkg::decoded_inst_t   dec_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::op_kind_e op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        op = rv_pkg::OP_NOP;
        if (opcode == rv_pkg::OPCODE_LW && funct3 == rv_pkg::FUNCT3_LW) begin
            op = rv_pkg::OP_LW;
        end else if (opcode == rv_pkg::OPCODE_SW && funct3 == rv_pkg::FUNCT3_SW) begin
            op = rv_pkg::OP_SW;
        end else if (opcode == rv_pkg::OPCODE_ADD && funct3 == rv_pkg::FUNCT3_ADD &&
                     funct7 == rv_pkg::FUNCT7_ADD) begin
            op = rv_pkg::OP_ADD;
        end else if (opcode == rv_pkg::OPCODE_SUB && funct3 == rv_pkg::FUNCT3_SUB &&
                     funct7 == rv_pkg::FUNCT7_SUB) begin
            op = rv_pkg::OP_SUB;
        end else if (opcode == rv_pkg::OPCODE_ADDI && funct3 == rv_pkg::FUNCT3_ADDI) begin
            op = rv_pkg::OP_ADDI;
        end else if (opcode == rv_pkg::OPCODE_ECALL && funct3 == rv_pkg::FUNCT3_ECALL &&
                     funct7 == rv_pkg::FUNCT7_ECALL) begin
            op = rv_pkg::OP_HALT;
        end
    end

    assign dec_o.op    = op;
    assign dec_o.rs1   = inst_i[19:15];
    assign dec_o.rs2   = inst_i[24:20];
    assign dec_o.rd    = inst_i[11:7];
    // sign extended 12-bit immediates
    assign dec_o.imm_i = {{(rv_pkg::XLEN-rv_pkg::IMM_W){inst_i[31]}}, inst_i[31:20]};
    assign dec_o.imm_s = {{(rv_pkg::XLEN-rv_pkg::IMM_W){inst_i[31]}}, inst_i[31:25],
                          inst_i[11:7]};

    // decoded kind must map back to the opcode it came from
    always_comb begin
        logic [6:0] exp_opcode;
        case (dec_o.op)
            rv_pkg::OP_LW:   exp_opcode = rv_pkg::OPCODE_LW;
            rv_pkg::OP_SW:   exp_opcode = rv_pkg::OPCODE_SW;
            rv_pkg::OP_ADD:  exp_opcode = rv_pkg::OPCODE_ADD;
            rv_pkg::OP_SUB:  exp_opcode = rv_pkg::OPCODE_SUB;
            rv_pkg::OP_ADDI: exp_opcode = rv_pkg::OPCODE_ADDI;
            rv_pkg::OP_HALT: exp_opcode = rv_pkg::OPCODE_ECALL;
            default:         exp_opcode = opcode;
        endcase
        assert (exp_opcode == opcode)
            else $error("decoded op %s disagrees with opcode %b", dec_o.op.name(), opcode);
    end

endmodule

/* src/inst_mem.sv */
`timescale 1ns/1ns

module inst_mem (
    input  logic                    clk,
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    output logic [rv_pkg::XLEN-1:0] inst_o,
    input  rv_pkg::mem_load_t       load_i
);

    logic [rv_pkg::XLEN-1:0]        mem [rv_pkg::IMEM_WORDS];
    logic [rv_pkg::IMEM_ADDR_W-1:0] fetch_idx;
    logic [rv_pkg::IMEM_ADDR_W-1:0] load_idx;

    // byte pc to word index
    assign fetch_idx = addr_i[rv_pkg::IMEM_ADDR_W+1:2];
    assign load_idx  = load_i.addr[rv_pkg::IMEM_ADDR_W-1:0];

    assign inst_o = mem[fetch_idx];

    always_ff @(posedge clk) begin
        if (load_i.we) begin
            mem[load_idx] <= load_i.data;
        end
    end

    // pc from the core stays word aligned
    a_fetch_aligned: assert property (@(posedge clk)
        !$isunknown(addr_i) |-> addr_i[1:0] == 2'b00)
        else $error("misaligned fetch address %h", addr_i);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_data_i
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // storage for x0 never picks up a write after reset
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0)
        else $error("x0 storage became nonzero");

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

    // widths and depths
    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMM_W       = 12;
    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);
    // one load struct serves both memories
    localparam int LOAD_ADDR_W = (IMEM_ADDR_W > DMEM_ADDR_W) ? IMEM_ADDR_W : DMEM_ADDR_W;

    // lw
    localparam logic [6:0] OPCODE_LW    = 7'b0000011;
    localparam logic [2:0] FUNCT3_LW    = 3'b010;
    // sw
    localparam logic [6:0] OPCODE_SW    = 7'b0100011;
    localparam logic [2:0] FUNCT3_SW    = 3'b010;
    // add and sub share opcode and funct3
    localparam logic [6:0] OPCODE_ADD   = 7'b0110011;
    localparam logic [2:0] FUNCT3_ADD   = 3'b000;
    localparam logic [6:0] FUNCT7_ADD   = 7'b0000000;
    localparam logic [6:0] OPCODE_SUB   = 7'b0110011;
    localparam logic [2:0] FUNCT3_SUB   = 3'b000;
    localparam logic [6:0] FUNCT7_SUB   = 7'b0100000;
    // addi
    localparam logic [6:0] OPCODE_ADDI  = 7'b0010011;
    localparam logic [2:0] FUNCT3_ADDI  = 3'b000;
    // ecall, used as halt
    localparam logic [6:0] OPCODE_ECALL = 7'b1110011;
    localparam logic [2:0] FUNCT3_ECALL = 3'b000;
    localparam logic [6:0] FUNCT7_ECALL = 7'b0000000;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_LW,
        OP_SW,
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_HALT
    } op_kind_e;

    typedef struct packed {
        op_kind_e              op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm_i;
        logic [XLEN-1:0]       imm_s;
    } decoded_inst_t;

    // byte address from the core
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wen;
    } dmem_req_t;

    // word index from the outside loader
    typedef struct packed {
        logic                   we;
        logic [LOAD_ADDR_W-1:0] addr;
        logic [XLEN-1:0]        data;
    } mem_load_t;

endpackage

/* src/rv_soc.sv */
`timescale 1ns/1ns

module rv_soc (
    input  logic                           clk,
    input  logic                           rst_n,
    input  rv_pkg::mem_load_t              imem_load_i,
    input  rv_pkg::mem_load_t              dmem_load_i,
    input  logic [rv_pkg::DMEM_ADDR_W-1:0] peek_addr_i,
    output logic [rv_pkg::XLEN-1:0]        peek_data_o,
    output logic                           exit_o
);

    logic [rv_pkg::XLEN-1:0] imem_addr;
    logic [rv_pkg::XLEN-1:0] inst_word;
    rv_pkg::dmem_req_t       dmem_req;
    logic [rv_pkg::XLEN-1:0] dmem_rdata;

    core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .inst_i       (inst_word),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_o)
    );

    inst_mem i_inst_mem (
        .clk    (clk),
        .addr_i (imem_addr),
        .inst_o (inst_word),
        .load_i (imem_load_i)
    );

    // peek port is for the testbench only
    data_mem i_data_mem (
        .clk         (clk),
        .req_i       (dmem_req),
        .rdata_o     (dmem_rdata),
        .load_i      (dmem_load_i),
        .peek_addr_i (peek_addr_i),
        .peek_data_o (peek_data_o)
    );

endmodule

/* tests/rv_programs.svh */
`ifndef RV_PROGRAMS_SVH
`define RV_PROGRAMS_SVH

// base formats
function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                       input logic [2:0] f3, input int rd,
                                       input logic [6:0] opc);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                       input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                       input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, rv_pkg::FUNCT3_LW, rd, rv_pkg::OPCODE_LW);
endfunction

function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return s_type(imm, rs2, rs1, rv_pkg::FUNCT3_SW, rv_pkg::OPCODE_SW);
endfunction

function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
    return r_type(rv_pkg::FUNCT7_ADD, rs2, rs1, rv_pkg::FUNCT3_ADD, rd, rv_pkg::OPCODE_ADD);
endfunction

function automatic logic [31:0] sub(input int rd, input int rs1, input int rs2);
    return r_type(rv_pkg::FUNCT7_SUB, rs2, rs1, rv_pkg::FUNCT3_SUB, rd, rv_pkg::OPCODE_SUB);
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_type(imm, rs1, rv_pkg::FUNCT3_ADDI, rd, rv_pkg::OPCODE_ADDI);
endfunction

function automatic logic [31:0] ecall();
    return r_type(rv_pkg::FUNCT7_ECALL, 0, 0, rv_pkg::FUNCT3_ECALL, 0, rv_pkg::OPCODE_ECALL);
endfunction

// ecall everywhere and a data pattern built from the word index
function automatic void clear_program();
    for (int i = 0; i < rv_pkg::IMEM_WORDS; i++) begin
        prog[i] = ecall();
    end
    for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
        dinit[i] = 32'hc0de_0000 ^ (i * 32'h0102_0305);
    end
endfunction

function automatic void build_arith();
    clear_program();
    prog[0] = addi(1, 0, 100);
    prog[1] = addi(2, 0, -7);
    prog[2] = add(3, 1, 2);
    prog[3] = sub(4, 2, 1);
    prog[4] = addi(5, 0, 2047);
    prog[5] = addi(6, 0, -2048);
    prog[6] = addi(7, 0, -1);
    // wraps past zero
    prog[7] = add(8, 7, 1);
    prog[8] = sub(9, 0, 6);
    prog[9] = sub(10, 6, 5);
    for (int r = 1; r <= 10; r++) begin
        prog[9 + r] = sw(r, 0, 4 * r);
    end
endfunction

function automatic void build_mem_round_trip();
    clear_program();
    prog[0] = addi(1, 0, 128);
    prog[1] = lw(2, 1, 0);
    prog[2] = lw(3, 1, -16);
    prog[3] = lw(4, 1, 40);
    prog[4] = lw(5, 1, -128);
    prog[5] = add(6, 2, 3);
    prog[6] = sub(7, 4, 5);
    prog[7] = sw(6, 0, 60);
    prog[8] = sw(7, 1, -4);
    prog[9] = sw(2, 1, 120);
endfunction

function automatic void build_x0();
    clear_program();
    prog[0] = addi(0, 0, 123);
    prog[1] = lw(0, 0, 8);
    prog[2] = sw(0, 0, 12);
    prog[3] = add(1, 0, 0);
    prog[4] = sw(1, 0, 16);
    prog[5] = addi(2, 0, 5);
    prog[6] = add(3, 0, 2);
    prog[7] = sw(3, 0, 20);
endfunction

// each foreign encoding would change x1 x3 or word 0 if it ran
function automatic void build_unsupported();
    clear_program();
    prog[0] = addi(1, 0, 11);
    prog[1] = {20'h12345, 5'd1, 7'b0110111};
    prog[2] = addi(2, 0, 22);
    prog[3] = i_type(3, 1, 3'b001, 1, rv_pkg::OPCODE_ADDI);
    prog[4] = r_type(7'b0000001, 2, 1, 3'b000, 1, rv_pkg::OPCODE_ADD);
    prog[5] = s_type(0, 1, 0, 3'b000, rv_pkg::OPCODE_SW);
    prog[6] = add(3, 1, 2);
    prog[7] = i_type(4, 0, 3'b000, 3, rv_pkg::OPCODE_LW);
    prog[8] = sw(3, 0, 8);
    prog[9] = i_type(0, 1, 3'b001, 1, rv_pkg::OPCODE_ECALL);
    prog[10] = sw(1, 0, 12);
endfunction

function automatic void build_halt(input int n);
    clear_program();
    for (int i = 0; i < n; i++) begin
        prog[i] = (i % 2 == 0) ? addi(i + 1, i, i + 1) : sw(i, 0, 4 * i);
    end
    prog[n] = ecall();
    // never reached
    prog[n + 1] = sw(0, 0, 0);
    prog[n + 2] = addi(5, 0, 9);
    prog[n + 3] = sw(5, 0, 4);
endfunction

// x31 holds the base 128 and is never a destination
function automatic logic [31:0] random_inst();
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    int base;
    int off;
    kind = $unsigned($random(seed)) % 6;
    rd = $unsigned($random(seed)) % 31;
    rs1 = $unsigned($random(seed)) % 31;
    rs2 = $unsigned($random(seed)) % 31;
    imm = $random(seed);
    base = imm[12] ? 31 : 0;
    off = 4 * int'(imm[5:0]) - (imm[12] ? 128 : 0);
    case (kind)
        0: return lw(rd, base, off);
        1: return sw(rs2, base, off);
        2: return add(rd, rs1, rs2);
        3: return sub(rd, rs1, rs2);
        4: return addi(rd, rs1, imm);
        default: return {imm[31:12], rd[4:0], 7'b0110111};
    endcase
endfunction

function automatic void build_random();
    int len;
    clear_program();
    for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
        dinit[i] = $random(seed);
    end
    len = 8 + ($unsigned($random(seed)) % 48);
    prog[0] = addi(31, 0, 128);
    for (int i = 1; i < len; i++) begin
        prog[i] = random_inst();
    end
endfunction

`endif

/* tests/tb_rv_soc.sv */
`timescale 1ns/1ns

module tb_rv_soc;

    localparam int EXIT_TIMEOUT    = 2000;
    localparam int RELEASE_TIMEOUT = 200;
    localparam int RANDOM_TESTS    = 20;

    logic                           clk = 1'b0;
    logic                           rst_n = 1'b0;
    rv_pkg::mem_load_t              imem_load = '0;
    rv_pkg::mem_load_t              dmem_load = '0;
    logic [rv_pkg::DMEM_ADDR_W-1:0] peek_addr = '0;
    logic [rv_pkg::XLEN-1:0]        peek_data;
    logic                           halted;

    // images shared with the program generators
    logic [rv_pkg::XLEN-1:0] prog    [rv_pkg::IMEM_WORDS];
    logic [rv_pkg::XLEN-1:0] dinit   [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::XLEN-1:0] exp_mem [rv_pkg::DMEM_WORDS];
    integer                  seed = 32'h1718_2b85;
    int                      pass_count = 0;
    int                      fail_count = 0;

    `include "rv_programs.svh"

    rv_soc i_rv_soc (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_load_i (imem_load),
        .dmem_load_i (dmem_load),
        .peek_addr_i (peek_addr),
        .peek_data_o (peek_data),
        .exit_o      (halted)
    );

    always #50 clk = ~clk;

    // runs prog on dinit into exp_mem and returns the cycles until ecall
    function automatic int run_model();
        logic [rv_pkg::XLEN-1:0] regs [rv_pkg::REG_COUNT];
        logic [rv_pkg::XLEN-1:0] w;
        logic [rv_pkg::XLEN-1:0] a;
        logic [rv_pkg::XLEN-1:0] b;
        logic [rv_pkg::XLEN-1:0] imm_i;
        logic [rv_pkg::XLEN-1:0] imm_s;
        logic [rv_pkg::XLEN-1:0] addr;
        logic [5:0]              pc;
        int                      cycles;
        for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
            exp_mem[i] = dinit[i];
        end
        pc = '0;
        cycles = 0;
        w = prog[pc];
        while (!(w[6:0] == rv_pkg::OPCODE_ECALL && w[14:12] == rv_pkg::FUNCT3_ECALL &&
                 w[31:25] == rv_pkg::FUNCT7_ECALL) && cycles < EXIT_TIMEOUT) begin
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            if (w[6:0] == rv_pkg::OPCODE_LW && w[14:12] == rv_pkg::FUNCT3_LW) begin
                addr = a + imm_i;
                regs[w[11:7]] = exp_mem[addr[rv_pkg::DMEM_ADDR_W+1:2]];
            end else if (w[6:0] == rv_pkg::OPCODE_SW && w[14:12] == rv_pkg::FUNCT3_SW) begin
                addr = a + imm_s;
                exp_mem[addr[rv_pkg::DMEM_ADDR_W+1:2]] = b;
            end else if (w[6:0] == rv_pkg::OPCODE_ADD && w[14:12] == rv_pkg::FUNCT3_ADD) begin
                if (w[31:25] == rv_pkg::FUNCT7_ADD) begin
                    regs[w[11:7]] = a + b;
                end else if (w[31:25] == rv_pkg::FUNCT7_SUB) begin
                    regs[w[11:7]] = a - b;
                end
            end else if (w[6:0] == rv_pkg::OPCODE_ADDI && w[14:12] == rv_pkg::FUNCT3_ADDI) begin
                regs[w[11:7]] = a + imm_i;
            end
            regs[0] = '0;
            pc = pc + 1'b1;
            cycles++;
            w = prog[pc];
        end
        return cycles;
    endfunction

    task automatic load_and_release();
        for (int i = 0; i < rv_pkg::IMEM_WORDS; i++) begin
            @(posedge clk);
            imem_load <= '{we: 1'b1, addr: rv_pkg::LOAD_ADDR_W'(i), data: prog[i]};
            if (i < rv_pkg::DMEM_WORDS) begin
                dmem_load <= '{we: 1'b1, addr: rv_pkg::LOAD_ADDR_W'(i), data: dinit[i]};
            end else begin
                dmem_load <= '0;
            end
        end
        @(posedge clk);
        imem_load <= '0;
        dmem_load <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic compare_result(input string name, input int exp_cycles);
        int guard;
        int cycles;
        int errors;
        guard = 0;
        while (!rst_n && guard < RELEASE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        // each negedge follows one executed instruction
        cycles = 0;
        while (!halted && cycles < EXIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n || !halted) begin
            $display("%s ended early because %s", name,
                     !rst_n ? "reset was never released" : "exit_o never rose in time");
            fail_count++;
        end else begin
            errors = 0;
            if (cycles != exp_cycles) begin
                $display("** Error %s cycles expected %0d actual %0d", name, exp_cycles, cycles);
                errors++;
            end
            for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
                @(posedge clk);
                peek_addr <= rv_pkg::DMEM_ADDR_W'(i);
                @(negedge clk);
                if (peek_data !== exp_mem[i]) begin
                    $display("** Error %s word %0d expected %h actual %h",
                             name, i, exp_mem[i], peek_data);
                    errors++;
                end
            end
            if (!halted) begin
                $display("%s exit_o fell while the core was halted", name);
                errors++;
            end
            if (errors == 0) begin
                pass_count++;
                $display("PASS %s in %0d cycles", name, cycles);
            end else begin
                fail_count++;
                $display("FAIL %s with %0d mismatches", name, errors);
            end
        end
    endtask

    task automatic run_test(input string name);
        int exp_cycles;
        exp_cycles = run_model();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        fork
            load_and_release();
            compare_result(name, exp_cycles);
        join
    endtask

    initial begin
        build_arith();
        run_test("arith");
        build_mem_round_trip();
        run_test("mem_round_trip");
        build_x0();
        run_test("x0_fixed");
        build_unsupported();
        run_test("unsupported");
        build_halt(0);
        run_test("halt_at_0");
        build_halt(11);
        run_test("halt_at_11");
        for (int t = 0; t < RANDOM_TESTS; t++) begin
            build_random();
            run_test($sformatf("random_%0d", t));
        end
        $display("%0d tests passed and %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
